//--- seq.f
+incdir+common
common/seq_pkg.sv
source/seq_rf.sv
source/seq_alu.sv
core/seq_core.sv
uart/uart_tx.sv
source/seq_top.sv
sim/tb_seq.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_seq
FILELIST  := seq.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal, the pass line decides the status
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "seq_defines.svh"

module tb_seq
   import seq_pkg::*;
();

   localparam int frame_clks = 10 * `SEQ_CLKS_PER_BIT; // Busy time of one frame
   localparam int n_pair     = 8;   // push then send
   localparam int n_chain    = 4;   // Chains per operation
   localparam int chain_len  = 5;
   localparam int n_rand     = 120;
   localparam int n_space    = 8;
   localparam int n_inst     = `SEQ_REG_N + 2 * n_pair + 2 * n_chain * (chain_len + 3)
                               + n_rand + 2 * n_space;
   localparam int cyc_limit  = n_inst * (frame_clks + 4) + 100;

   logic      clk = 1'b0;
   logic      rst;
   seq_inst_u inst;
   logic      inst_valid;
   logic      txd;

   logic [`SEQ_DATA_W-1:0] regs [`SEQ_REG_N]; // Reference registers
   logic [`SEQ_TX_W-1:0]   exp_q [$];         // Bytes still to come
   int cyc      = 0;
   int last_acc = -1000;  // Issue cycle of the last accepted send
   int errors   = 0;
   int tests    = 0;
   int bad      = 0;
   int drops    = 0;
   int rx_cnt   = 0;

   always #4 clk = ~clk; // 8 ns period

   seq_top dut0 (
      .clk          (clk),
      .i_rst        (rst),
      .i_inst       (inst),
      .i_inst_valid (inst_valid),
      .o_uart_txd   (txd)
   );

   // Watchdog
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= cyc_limit) begin
         $display("Timeout after %0d cycles, the run did not finish", cyc);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // ==================================================
   // Stimulus and reference model
   // ==================================================

   function automatic int pick(input int n);
      return int'($urandom % n);
   endfunction

   function automatic seq_inst_u mk_push(input int ra, input int c);
      seq_inst_u w;
      w                = '0;
      w.push.op        = seq_op_push;
      w.push.ra        = `SEQ_REG_W'(ra);  // Destination
      w.push.const_val = `SEQ_CONST_W'(c);
      return w;
   endfunction

   function automatic seq_inst_u mk_rr(input seq_op_e op, input int ra, input int rb,
                                       input int rc);
      seq_inst_u w;
      w       = '0;
      w.rr.op = op;
      w.rr.ra = `SEQ_REG_W'(ra);
      w.rr.rb = `SEQ_REG_W'(rb);
      w.rr.rc = `SEQ_REG_W'(rc);
      return w;
   endfunction

   // Executes at issue since forwarding in the DUT makes that exact
   task automatic model_exec(input seq_inst_u w);
      case (w.rr.op)
         seq_op_push: regs[w.push.ra] = {8'h00, w.push.const_val};
         seq_op_add:  regs[w.rr.rc] = regs[w.rr.ra] + regs[w.rr.rb];
         seq_op_mult: regs[w.rr.rc] = regs[w.rr.ra] * regs[w.rr.rb]; // Low half
         default: begin
            if (cyc - last_acc > frame_clks) begin // Transmitter idle again
               exp_q.push_back(regs[w.rr.ra][`SEQ_TX_W-1:0]);
               last_acc = cyc;
            end else begin
               drops++;  // Lost while busy
            end
         end
      endcase
   endtask

   task automatic issue(input seq_inst_u w);
      @(posedge clk);
      inst       <= w;
      inst_valid <= 1'b1;
      model_exec(w);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         inst       <= `SEQ_INST_W'($urandom); // Junk word without strobe
         inst_valid <= 1'b0;
      end
   endtask

   // Next issue lands after the frame
   task automatic wait_tx_free();
      do begin
         idle(1);
      end while (cyc + 1 - last_acc <= frame_clks);
   endtask

   task automatic idle_check(input int n);
      repeat (n) begin
         idle(1);
         @(negedge clk);
         assert (txd === 1'b1) else begin
            $display("FAILED t=%0t o_uart_txd got %b exp 1", $time, txd);
            errors++;
         end
      end
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      do begin
         idle(1);
         waited++;
      end while ((exp_q.size() != 0 || cyc - last_acc <= frame_clks + 2)
                 && waited < 3 * frame_clks);
      assert (exp_q.size() == 0) else begin
         $display("ERROR: %0d expected bytes never appeared on the line", exp_q.size());
         errors++;
         exp_q.delete();
      end
   endtask

   // Dependent ops back to back with the result seen through a send
   task automatic run_chain(input seq_op_e op);
      int a;
      int b;
      int nd;
      a = pick(`SEQ_REG_N);
      b = pick(`SEQ_REG_N);
      wait_tx_free();
      issue(mk_push(a, pick(256)));
      issue(mk_push(b, pick(256)));
      for (int i = 0; i < chain_len; i++) begin
         nd = pick(`SEQ_REG_N);
         issue(mk_rr(op, a, (pick(2) != 0) ? a : b, nd)); // Reads the last result
         a = nd;
      end
      issue(mk_rr(seq_op_send, a, 0, 0));
   endtask

   task automatic end_test(input string name, input int err0);
      tests++;
      if (errors != err0) bad++;
      $display("test %0s: %0s, %0d errors", name, (errors == err0) ? "ok" : "bad",
               errors - err0);
   endtask

   // ==================================================
   // Line monitor
   // ==================================================

   task automatic receive_frame();
      logic [`SEQ_TX_W-1:0] got;
      logic [`SEQ_TX_W-1:0] want;
      got = '0;
      repeat (`SEQ_CLKS_PER_BIT / 2) @(negedge clk); // Middle of start bit
      assert (txd === 1'b0) else begin
         $display("ERROR: start bit did not hold at %0t", $time);
         errors++;
      end
      for (int k = 0; k < `SEQ_TX_W; k++) begin
         repeat (`SEQ_CLKS_PER_BIT) @(negedge clk);
         got[k] = txd;  // LSB first
      end
      repeat (`SEQ_CLKS_PER_BIT) @(negedge clk);
      assert (txd === 1'b1) else begin
         $display("ERROR: stop bit not high at %0t", $time);
         errors++;
      end
      rx_cnt++;
      assert (exp_q.size() != 0) else begin
         $display("ERROR: frame %02h at %0t when no byte was expected", got, $time);
         errors++;
      end
      if (exp_q.size() != 0) begin
         want = exp_q.pop_front();
         assert (got === want) else begin
            $display("FAILED t=%0t o_uart_txd byte got %02h exp %02h", $time, got, want);
            errors++;
         end
      end
   endtask

   initial begin : line_monitor
      logic prev_txd;
      prev_txd = 1'b1;
      forever begin
         @(negedge clk);
         if (!rst && prev_txd === 1'b1 && txd === 1'b0) begin
            receive_frame();
         end
         prev_txd = txd;
      end
   end

   // ==================================================
   // Test sequence
   // ==================================================

   initial begin : main
      int err0;
      int dst;
      int gap;
      void'($urandom(3));
      rst        = 1'b1;
      inst       = '0;
      inst_valid = 1'b0;
      for (int r = 0; r < `SEQ_REG_N; r++) regs[r] = '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      err0 = errors;  // Quiet line first and every register reads zero
      idle_check(2 * frame_clks);
      for (int r = 0; r < `SEQ_REG_N; r++) begin
         wait_tx_free();
         issue(mk_rr(seq_op_send, r, 0, 0));
      end
      drain();
      end_test("reset_zero", err0);

      err0 = errors;
      for (int i = 0; i < n_pair; i++) begin
         wait_tx_free();
         dst = pick(`SEQ_REG_N);
         issue(mk_push(dst, pick(256)));
         issue(mk_rr(seq_op_send, dst, 0, 0)); // Very next cycle
      end
      drain();
      end_test("push_send", err0);

      err0 = errors;
      for (int i = 0; i < n_chain; i++) run_chain(seq_op_add);
      drain();
      end_test("add_chain", err0);

      err0 = errors;
      for (int i = 0; i < n_chain; i++) run_chain(seq_op_mult);
      drain();
      end_test("mult_chain", err0);

      err0 = errors;  // Dense mix where many sends hit a busy line
      for (int i = 0; i < n_rand; i++) begin
         case (pick(8))
            0, 1:    issue(mk_push(pick(`SEQ_REG_N), pick(256)));
            2:       issue(mk_rr(seq_op_add, pick(16), pick(16), pick(16)));
            3:       issue(mk_rr(seq_op_mult, pick(16), pick(16), pick(16)));
            default: issue(mk_rr(seq_op_send, pick(16), 0, 0));
         endcase
         gap = pick(4);
         if (gap > 0) idle(gap);
      end
      drain();
      assert (drops > 0) else begin
         $display("ERROR: no send was ever dropped, busy path not exercised");
         errors++;
      end
      end_test("busy_drop", err0);

      err0 = errors;
      for (int i = 0; i < n_space; i++) begin
         dst = pick(`SEQ_REG_N);
         issue(mk_push(dst, pick(256)));
         wait_tx_free();
         issue(mk_rr(seq_op_send, dst, 0, 0));
      end
      drain();
      end_test("spaced_send", err0);

      err0 = errors;  // One frame of quiet line at the end
      idle_check(frame_clks);
      assert (exp_q.size() == 0) else begin
         $display("ERROR: %0d bytes left in the expected queue", exp_q.size());
         errors++;
      end
      end_test("final_idle", err0);

      $display("%0d tests, %0d failed, %0d frames, %0d sends dropped, %0d errors",
               tests, bad, rx_cnt, drops, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- source/seq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "seq_defines.svh"

module seq_top
   import seq_pkg::*;
(
   input  wire       clk,
   input  wire       i_rst,
   input  seq_inst_u i_inst,        // Instruction word
   input  wire       i_inst_valid,  // No back-pressure
   output logic      o_uart_txd     // Serial out, idle high
);

   logic [`SEQ_TX_W-1:0] tx_data;
   logic                 tx_valid;
   logic                 tx_busy;   // Frame in progress

   // ==================================================
   // Sequencer core
   // ==================================================

   seq_core core0 (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_inst       (i_inst),
      .i_inst_valid (i_inst_valid),
      .i_tx_busy    (tx_busy),
      .o_tx_data    (tx_data),
      .o_tx_valid   (tx_valid)
   );

   // ==================================================
   // Serial transmitter
   // ==================================================

   uart_tx tx0 (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_data  (tx_data),
      .i_valid (tx_valid),
      .o_busy  (tx_busy),
      .o_txd   (o_uart_txd)
   );

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "seq_defines.svh"

module uart_tx (
   input  wire                  clk,
   input  wire                  i_rst,
   input  wire  [`SEQ_TX_W-1:0] i_data,   // Byte to frame
   input  wire                  i_valid,  // Single-cycle strobe only while idle
   output logic                 o_busy,   // High for the whole frame
   output logic                 o_txd     // Serial line, idle high
);

   localparam int cnt_w = $clog2(`SEQ_CLKS_PER_BIT + 1);
   localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`SEQ_CLKS_PER_BIT - 1);
   localparam logic [3:0] bit_last = 4'd`SEQ_TX_W + 4'd1; // Stop bit index

   logic [cnt_w-1:0]   clk_cnt;  // Clocks into the current bit
   logic [3:0]         bit_idx;  // 0 start, 1..8 data, 9 stop
   logic [`SEQ_TX_W:0] shift;    // Data LSB first, then stop
   logic               bit_end;

   assign bit_end = (clk_cnt == cnt_last);

   // ==================================================
   // Control
   // ==================================================

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_busy  <= 1'b0;
         o_txd   <= 1'b1;  // Line idle
         clk_cnt <= '0;
         bit_idx <= '0;
      end else if (!o_busy) begin
         if (i_valid) begin
            o_busy  <= 1'b1;
            o_txd   <= 1'b0;  // Start bit from the next cycle
            clk_cnt <= '0;
            bit_idx <= '0;
         end
      end else if (bit_end) begin
         clk_cnt <= '0;
         if (bit_idx == bit_last) begin
            o_busy <= 1'b0;   // Stop bit done with the line already high
         end else begin
            bit_idx <= bit_idx + 4'd1;
            o_txd   <= shift[0];
         end
      end else begin
         clk_cnt <= clk_cnt + 1'b1;
      end
   end

   // ==================================================
   // Shift register
   // ==================================================

   always_ff @(posedge clk) begin
      if (!o_busy && i_valid) begin
         shift <= {1'b1, i_data}; // Stop bit rides at the top
      end else if (o_busy && bit_end) begin
         shift <= {1'b1, shift[`SEQ_TX_W:1]};
      end
   end

   // Sender side promises not to strobe into a running frame
   a_no_strobe_busy: assert property (
      @(posedge clk) disable iff (i_rst)
      o_busy |-> !i_valid
   ) else $error("uart_tx: strobe while busy");

endmodule

`default_nettype wire

//--- core/seq_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "seq_defines.svh"

module seq_core
   import seq_pkg::*;
(
   input  wire                        clk,
   input  wire                        i_rst,
   // Instruction in
   input  seq_inst_u                  i_inst,
   input  wire                        i_inst_valid, // One cycle per instruction
   // Transmitter side
   input  wire                        i_tx_busy,
   output logic [`SEQ_TX_W-1:0]       o_tx_data,
   output logic                       o_tx_valid
);

   seq_op_e                inst_op;     // Same bits in both forms
   logic                   op_send;
   logic                   op_push;
   logic [`SEQ_REG_W-1:0]  inst_dest;

   logic [`SEQ_DATA_W-1:0] rf_data_a;
   logic [`SEQ_DATA_W-1:0] rf_data_b;

   seq_alu_req_t           alu_req;
   logic                   alu_req_valid;
   seq_wb_t                alu_wb;
   logic                   alu_wb_valid;

   // ==================================================
   // Decode
   // ==================================================

   assign inst_op = i_inst.rr.op;
   assign op_push = (inst_op == seq_op_push);
   assign op_send = (inst_op == seq_op_send);

   // Push writes ra of its own form and the rest write rc
   assign inst_dest = op_push ? i_inst.push.ra : i_inst.rr.rc;

   // ==================================================
   // Register file
   // ==================================================

   seq_rf rf0 (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_sel_a    (i_inst.rr.ra),  // Also the send source
      .i_sel_b    (i_inst.rr.rb),
      .i_wb       (alu_wb),
      .i_wb_valid (alu_wb_valid),
      .o_data_a   (rf_data_a),
      .o_data_b   (rf_data_b)
   );

   // ==================================================
   // ALU
   // ==================================================

   always_comb begin
      alu_req.op        = inst_op;
      alu_req.a         = rf_data_a;
      alu_req.b         = rf_data_b;
      alu_req.const_val = i_inst.push.const_val; // Ignored unless push
      alu_req.dest      = inst_dest;
   end

   assign alu_req_valid = i_inst_valid & ~op_send; // Push, add and mult

   seq_alu alu0 (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_req   (alu_req),
      .i_valid (alu_req_valid),
      .o_wb    (alu_wb),
      .o_valid (alu_wb_valid)
   );

   // ==================================================
   // Send
   // ==================================================

   // Forwarded read lets a send right after a push see the new value
   assign o_tx_data  = rf_data_a[`SEQ_TX_W-1:0];
   // Dropped while a frame is on the line
   assign o_tx_valid = i_inst_valid & op_send & ~i_tx_busy;

   // Strobe only when idle, and the transmitter takes it on that edge
   a_tx_handshake: assert property (
      @(posedge clk) disable iff (i_rst)
      o_tx_valid |-> !i_tx_busy ##1 i_tx_busy
   ) else $error("seq_core: send strobe not taken by the transmitter");

endmodule

`default_nettype wire

//--- source/seq_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "seq_defines.svh"

module seq_alu
   import seq_pkg::*;
(
   input  wire          clk,
   input  wire          i_rst,
   input  seq_alu_req_t i_req,   // Operands, opcode and destination
   input  wire          i_valid,
   output seq_wb_t      o_wb,    // Result tagged with its destination
   output logic         o_valid
);

   logic [`SEQ_DATA_W-1:0] result; // Combinational result of this cycle

   // ==================================================
   // Operation select
   // ==================================================

   always_comb begin
      unique case (i_req.op)
         seq_op_push: result = {{(`SEQ_DATA_W-`SEQ_CONST_W){1'b0}}, i_req.const_val};
         seq_op_add:  result = i_req.a + i_req.b;   // Wraps at 16 bits
         seq_op_mult: result = i_req.a * i_req.b;   // Truncated to the low half
         default:     result = '0;                  // Send stays in the core
      endcase
   end

   // ==================================================
   // Output stage
   // ==================================================

   // Strobe cleared by reset
   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_valid <= 1'b0;
      end else begin
         o_valid <= i_valid;
      end
   end

   // Payload loaded on a request
   always_ff @(posedge clk) begin
      if (i_valid) begin
         o_wb.dest <= i_req.dest; // Destination travels with the data
         o_wb.data <= result;
      end
   end

   // Each request is a real write and returns one cycle later
   a_latency: assert property (
      @(posedge clk) disable iff (i_rst)
      i_valid |-> (i_req.op != seq_op_send) ##1 o_valid
   ) else $error("seq_alu: send opcode on the request or result missing a cycle later");

endmodule

`default_nettype wire

//--- source/seq_rf.sv
`timescale 1ns/1ps
`default_nettype none

`include "seq_defines.svh"

module seq_rf
   import seq_pkg::*;
(
   input  wire                          clk,
   input  wire                          i_rst,
   input  wire  [`SEQ_REG_W-1:0]        i_sel_a,    // Read port a select
   input  wire  [`SEQ_REG_W-1:0]        i_sel_b,    // Read port b select
   input  seq_wb_t                      i_wb,       // Write port from the ALU
   input  wire                          i_wb_valid,
   output logic [`SEQ_DATA_W-1:0]       o_data_a,
   output logic [`SEQ_DATA_W-1:0]       o_data_b
);

   logic [`SEQ_DATA_W-1:0] regs [`SEQ_REG_N]; // Architectural registers

   // Pending write wins over the stored value
   function automatic logic [`SEQ_DATA_W-1:0] rd_port(input logic [`SEQ_REG_W-1:0] sel);
      if (i_wb_valid && (i_wb.dest == sel)) begin
         return i_wb.data; // Forwarded
      end
      return regs[sel];
   endfunction

   // ==================================================
   // Write port
   // ==================================================

   always_ff @(posedge clk) begin
      if (i_rst) begin
         for (int i = 0; i < `SEQ_REG_N; i++) begin
            regs[i] <= '0; // All registers start at zero
         end
      end else if (i_wb_valid) begin
         regs[i_wb.dest] <= i_wb.data;
      end
   end

   // ==================================================
   // Read ports with forwarding
   // ==================================================

   always_comb begin
      o_data_a = rd_port(i_sel_a);
      o_data_b = rd_port(i_sel_b);
   end

   // An unknown write would spread through every later dependent read
   a_wb_known: assert property (
      @(posedge clk) disable iff (i_rst)
      i_wb_valid |-> !$isunknown(i_wb.data)
   ) else $error("seq_rf: write data unknown for r%0d", i_wb.dest);

endmodule

`default_nettype wire

//--- common/seq_pkg.sv
`default_nettype none

`include "seq_defines.svh"

package seq_pkg;

   // ==================================================
   // Instruction encoding
   // ==================================================

   typedef enum logic [1:0] {
      seq_op_push = 2'b00, // Load zero-extended constant
      seq_op_add  = 2'b01, // rc = ra + rb
      seq_op_mult = 2'b10, // rc = low half of ra * rb
      seq_op_send = 2'b11  // Transmit low byte of ra
   } seq_op_e;

   // Push form with the destination right under the opcode
   typedef struct packed {
      seq_op_e                                          op;
      logic [`SEQ_REG_W-1:0]                            ra;        // Destination
      logic [`SEQ_INST_W-2-`SEQ_REG_W-`SEQ_CONST_W-1:0] pad;
      logic [`SEQ_CONST_W-1:0]                          const_val;
   } seq_push_t;

   // Register form with two sources and a destination
   typedef struct packed {
      seq_op_e                               op;
      logic [`SEQ_INST_W-2-3*`SEQ_REG_W-1:0] pad;
      logic [`SEQ_REG_W-1:0]                 ra;  // Source a and the send source
      logic [`SEQ_REG_W-1:0]                 rb;  // Source b
      logic [`SEQ_REG_W-1:0]                 rc;  // Destination
   } seq_rr_t;

   // Same word read two ways by opcode
   typedef union packed {
      seq_push_t push;
      seq_rr_t   rr;
   } seq_inst_u;

   // ==================================================
   // Pipeline payloads
   // ==================================================

   typedef struct packed {
      seq_op_e                 op;
      logic [`SEQ_DATA_W-1:0]  a;
      logic [`SEQ_DATA_W-1:0]  b;
      logic [`SEQ_CONST_W-1:0] const_val;
      logic [`SEQ_REG_W-1:0]   dest;
   } seq_alu_req_t;

   typedef struct packed {
      logic [`SEQ_REG_W-1:0]  dest;
      logic [`SEQ_DATA_W-1:0] data;
   } seq_wb_t;

endpackage

`default_nettype wire

//--- common/seq_defines.svh
`ifndef SEQ_DEFINES_SVH
`define SEQ_DEFINES_SVH

// ==================================================
// Word and datapath widths
// ==================================================

`define SEQ_INST_W 16 // Instruction word
`define SEQ_DATA_W 16 // Register and ALU width
`define SEQ_CONST_W 8 // Push immediate

// ==================================================
// Register file
// ==================================================

`define SEQ_REG_N 16 // Register count
`define SEQ_REG_W 4  // Register number width

// ==================================================
// Serial transmitter
// ==================================================

`define SEQ_TX_W 8 // One frame carries a byte

`define SEQ_CLKS_PER_BIT 4 // Bit period in clocks

`endif
